//--- rtl/fetch_pkg.sv
package fetch_pkg;

    // basic widths
    parameter int XLEN           = 32;
    parameter int BEAT_WIDTH     = 64;   // one memory beat
    parameter int LINE_WIDTH     = 256;  // one instruction line
    parameter int BEATS_PER_LINE = LINE_WIDTH / BEAT_WIDTH;

    // byte offset bits inside a line
    parameter int LINE_OFFSET_BITS = $clog2(LINE_WIDTH / 8);

    // reset vector of the core
    parameter logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // one fetched instruction with its pc
    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_entry_t;

    // redirect from the back end
    // pc is the new fetch target
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    // line read request towards burst memory
    typedef struct packed {
        logic            read;
        logic [XLEN-1:0] addr;  // always line aligned
    } line_req_t;

endpackage

//--- rtl/burst_assembler.sv
`timescale 1ns/10ps

module burst_assembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [fetch_pkg::BEAT_WIDTH-1:0] rdata_i,
    input  logic                             rvalid_i,
    output logic [fetch_pkg::LINE_WIDTH-1:0] line_o,
    output logic                             line_valid_o
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(BEATS_PER_LINE);

    logic [CNT_W-1:0] beat_cnt;
    logic             last_beat;

    // fourth beat of the current line
    assign last_beat = rvalid_i && (beat_cnt == CNT_W'(BEATS_PER_LINE - 1));

    // beats come lowest first, so shift in from the top
    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            line_o <= {rdata_i, line_o[LINE_WIDTH-1:BEAT_WIDTH]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;  // one cycle after beat 4
            if (last_beat) begin
                beat_cnt <= '0;
            end else if (rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/10ps

module line_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [fetch_pkg::XLEN-1:0]       lookup_pc_i,
    output logic                             hit_o,
    output logic [fetch_pkg::XLEN-1:0]       word_o,
    output fetch_pkg::line_req_t             req_o,
    input  logic                             req_ready_i,
    input  logic [fetch_pkg::LINE_WIDTH-1:0] fill_line_i,
    input  logic                             fill_valid_i
);
    import fetch_pkg::*;

    localparam int TAG_W = XLEN - LINE_OFFSET_BITS;

    logic [LINE_WIDTH-1:0]         line_q;
    logic [TAG_W-1:0]              tag_q;
    logic                          valid_q;
    logic                          pending_q;  // fill requested, line not back yet
    line_req_t                     req_q;
    logic [LINE_OFFSET_BITS-3:0]   word_sel;

    assign hit_o    = valid_q && (tag_q == lookup_pc_i[XLEN-1:LINE_OFFSET_BITS]);
    assign word_sel = lookup_pc_i[LINE_OFFSET_BITS-1:2];
    assign word_o   = line_q[word_sel*XLEN +: XLEN];
    assign req_o    = req_q;

    // line storage, tag comes from the address that was requested
    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            line_q <= fill_line_i;
            tag_q  <= req_q.addr[XLEN-1:LINE_OFFSET_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            pending_q <= 1'b0;
            req_q     <= '0;
        end else begin
            if (fill_valid_i) begin
                valid_q   <= 1'b1;
                pending_q <= 1'b0;
            end

            if (req_q.read) begin
                // hold addr and read until memory takes it
                if (req_ready_i) begin
                    req_q.read <= 1'b0;
                    pending_q  <= 1'b1;
                end
            end else if (!pending_q && !hit_o) begin
                req_q.read <= 1'b1;
                req_q.addr <= {lookup_pc_i[XLEN-1:LINE_OFFSET_BITS],
                               {LINE_OFFSET_BITS{1'b0}}};
            end
        end
    end

endmodule

//--- rtl/fetch_pc_gen.sv
`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  fetch_pkg::redirect_t       redirect_i,
    input  logic                       hit_i,
    input  logic [fetch_pkg::XLEN-1:0] word_i,
    input  logic                       queue_full_i,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic                       enq_o,
    output fetch_pkg::fetch_entry_t    enq_entry_o,
    output logic                       flush_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] target;

    // redirect target, forced to a word boundary
    assign target = {redirect_i.pc[XLEN-1:2], 2'b00};

    // redirect wins over a normal fetch
    assign flush_o = redirect_i.valid;
    assign enq_o   = hit_i && !queue_full_i && !redirect_i.valid;

    assign enq_entry_o.inst = word_i;
    assign enq_entry_o.pc   = pc_q;
    assign pc_o             = pc_q;

    always_comb begin
        pc_next = pc_q;  // hold on miss or full queue
        if (redirect_i.valid) begin
            pc_next = target;
        end else if (enq_o) begin
            pc_next = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

//--- rtl/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enq_i,
    input  fetch_pkg::fetch_entry_t enq_entry_i,
    input  logic                    deq_i,
    input  logic                    flush_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    full_o,
    output logic                    empty_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;  // one extra bit to reach QUEUE_DEPTH
    logic             do_enq;
    logic             do_deq;

    assign full_o  = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign empty_o = (count == '0);
    assign entry_o = mem[head];  // oldest entry

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail] <= enq_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= tail + 1'b1;  // wraps, depth is a power of two
            end
            if (do_deq) begin
                head <= head + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both in one cycle
            endcase
        end
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    // burst memory
    output logic [fetch_pkg::XLEN-1:0]       bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [fetch_pkg::BEAT_WIDTH-1:0] bmem_rdata_i,
    input  logic                             bmem_rvalid_i,
    // back end
    input  fetch_pkg::redirect_t             redirect_i,
    input  logic                             deq_i,
    output fetch_pkg::fetch_entry_t          entry_o,
    output logic                             empty_o
);
    import fetch_pkg::*;

    logic [LINE_WIDTH-1:0] fill_line;
    logic                  fill_valid;
    line_req_t             line_req;
    logic                  hit;
    logic [XLEN-1:0]       word;
    logic [XLEN-1:0]       pc;
    logic                  queue_full;
    logic                  enq;
    logic                  flush;
    fetch_entry_t          enq_entry;

    assign bmem_read_o = line_req.read;
    assign bmem_addr_o = line_req.addr;

    burst_assembler burst_assembler_i (
        .clk          (clk),
        .rst          (rst),
        .rdata_i      (bmem_rdata_i),
        .rvalid_i     (bmem_rvalid_i),
        .line_o       (fill_line),
        .line_valid_o (fill_valid)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (pc),
        .hit_o        (hit),
        .word_o       (word),
        .req_o        (line_req),
        .req_ready_i  (bmem_ready_i),
        .fill_line_i  (fill_line),
        .fill_valid_i (fill_valid)
    );

    fetch_pc_gen fetch_pc_gen_i (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .hit_i        (hit),
        .word_i       (word),
        .queue_full_i (queue_full),
        .pc_o         (pc),
        .enq_o        (enq),
        .enq_entry_o  (enq_entry),
        .flush_o      (flush)
    );

    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch_queue_i (
        .clk         (clk),
        .rst         (rst),
        .enq_i       (enq),
        .enq_entry_i (enq_entry),
        .deq_i       (deq_i),
        .flush_i     (flush),
        .entry_o     (entry_o),
        .full_o      (queue_full),
        .empty_o     (empty_o)
    );

endmodule

//--- sim/fetch_checker.sv
`timescale 1ns/10ps

module fetch_checker (
    input logic                       clk,
    input logic                       rst,
    input logic [fetch_pkg::XLEN-1:0] bmem_addr_i,
    input logic                       bmem_read_i,
    input logic                       bmem_ready_i,
    input logic [fetch_pkg::XLEN-1:0] pc_i,
    input logic                       flush_i,
    input logic                       empty_i
);
    import fetch_pkg::*;

    // sticky, one per property
    logic align_fail = 1'b0;
    logic hold_fail  = 1'b0;
    logic line_fail  = 1'b0;
    logic flush_fail = 1'b0;
    logic any_fail;

    assign any_fail = align_fail || hold_fail || line_fail || flush_fail;

    request_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_addr_i[LINE_OFFSET_BITS-1:0] == '0)
        else begin
            align_fail = 1'b1;
            $error("memory request address %h is not line aligned", bmem_addr_i);
        end

    // read and addr held until the memory takes the request
    request_held: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i && !bmem_ready_i |=> bmem_read_i && $stable(bmem_addr_i))
        else begin
            hold_fail = 1'b1;
            $error("memory request dropped or changed before ready");
        end

    request_line: assert property (@(posedge clk) disable iff (rst)
        $rose(bmem_read_i) |->
            bmem_addr_i[XLEN-1:LINE_OFFSET_BITS] == $past(pc_i[XLEN-1:LINE_OFFSET_BITS]))
        else begin
            line_fail = 1'b1;
            $error("memory request %h is not for the line of the fetch pc", bmem_addr_i);
        end

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> empty_i)
        else begin
            flush_fail = 1'b1;
            $error("fetch queue not empty in the cycle after a flush");
        end

endmodule

bind fetch_top fetch_checker fetch_checker_i (
    .clk          (clk),
    .rst          (rst),
    .bmem_addr_i  (bmem_addr_o),
    .bmem_read_i  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .pc_i         (pc),
    .flush_i      (flush),
    .empty_i      (empty_o)
);

//--- sim/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int          DEPTH     = 8;
    localparam int          NUM_ROWS  = 9;
    localparam logic [31:0] RAND_SEED = 32'h1eabc3d7;

    // one row: entries to consume, idle cycles with deq low, then an optional redirect
    typedef struct packed {
        logic [15:0] consume;
        logic [15:0] stall;
        redirect_t   redir;
    } scenario_t;

    localparam scenario_t SCENARIOS [NUM_ROWS] = '{
        '{16'd3,  16'd0,  '{1'b0, 32'h00000000}},  // first entries after reset
        '{16'd21, 16'd40, '{1'b0, 32'h00000000}},  // line crossings, then a full queue
        '{16'd5,  16'd40, '{1'b1, 32'h1eceb088}},  // target inside the buffered line
        '{16'd12, 16'd0,  '{1'b1, 32'h20004016}},  // new line, unaligned target
        '{16'd30, 16'd3,  '{1'b1, 32'h1eceb000}},
        '{16'd9,  16'd0,  '{1'b0, 32'h00000000}},
        '{16'd0,  16'd2,  '{1'b1, 32'h1eceb100}},
        '{16'd0,  16'd0,  '{1'b1, 32'h300000fe}},  // while a fill may still be pending
        '{16'd16, 16'd0,  '{1'b0, 32'h00000000}}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic [XLEN-1:0]       bmem_addr_o;
    logic                  bmem_read_o;
    logic                  bmem_ready_i;
    logic [BEAT_WIDTH-1:0] bmem_rdata_i;
    logic                  bmem_rvalid_i;
    redirect_t             redirect_i;
    logic                  deq_i;
    fetch_entry_t          entry_o;
    logic                  empty_o;
    logic [XLEN-1:0]       exp_pc;  // pc of the next entry the consumer must see

    always #2 clk = ~clk;

    fetch_top #(.QUEUE_DEPTH(DEPTH)) UUT (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .redirect_i    (redirect_i),
        .deq_i         (deq_i),
        .entry_o       (entry_o),
        .empty_o       (empty_o)
    );

    // memory content, address xor constant, rotated left by 7
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'hc0de0000;
        return {x[24:0], x[31:25]};
    endfunction

    function automatic int unsigned timeout_cycles();
        int unsigned total;
        total = 32'd200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            // a line refill costs about 20 cycles per 8 entries
            total = total + 32'(SCENARIOS[i].consume) * 32'd12
                  + 32'(SCENARIOS[i].stall) + 32'd60;
        end
        return total;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_entry();
        logic [31:0] exp_inst;
        exp_inst = mem_word(exp_pc);
        assert (entry_o.pc == exp_pc)
            else report_failure($sformatf("mismatch entry_o.pc: got %h, expected %h",
                                          entry_o.pc, exp_pc));
        assert (entry_o.inst == exp_inst)
            else report_failure($sformatf("mismatch entry_o.inst at pc %h: got %h, expected %h",
                                          exp_pc, entry_o.inst, exp_inst));
        exp_pc = exp_pc + 32'd4;
    endtask

    // deq stays high until n entries have actually left the queue
    task automatic consume_entries(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge clk);
            deq_i <= 1'b1;
            @(negedge clk);
            if (!empty_o) begin
                check_entry();
                got++;
            end
        end
        @(posedge clk);
        deq_i <= 1'b0;
    endtask

    task automatic apply_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect_i <= '{valid: 1'b1, pc: target};
        @(posedge clk);
        redirect_i <= '0;
        exp_pc = {target[31:2], 2'b00};  // fetch restarts at the aligned target
    endtask

    initial begin : memory_model
        logic [31:0] beat_addr;
        int unsigned wait_cycles;
        bmem_ready_i  = 1'b0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        void'($urandom(RAND_SEED));
        forever begin
            @(negedge clk);
            if (!rst && bmem_read_o) begin
                beat_addr   = bmem_addr_o;
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) @(posedge clk);
                @(posedge clk);
                bmem_ready_i <= 1'b1;
                @(posedge clk);
                bmem_ready_i <= 1'b0;  // request taken on this edge
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    wait_cycles = $urandom % 3;
                    repeat (wait_cycles) begin
                        @(posedge clk);
                        bmem_rvalid_i <= 1'b0;
                    end
                    @(posedge clk);
                    bmem_rdata_i  <= {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
                    bmem_rvalid_i <= 1'b1;
                    beat_addr = beat_addr + 32'd8;
                end
                @(posedge clk);
                bmem_rvalid_i <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = timeout_cycles();
        repeat (limit) @(posedge clk);
        report_failure($sformatf("timeout: scenario table not done after %0d cycles", limit));
    end

    // sticky flag from the bound checker
    always @(negedge clk) begin
        if (UUT.fetch_checker_i.any_fail) begin
            report_failure("a bound assertion on the memory or queue side failed");
        end
    end

    initial begin : stimulus
        rst        = 1'b1;
        deq_i      = 1'b0;
        redirect_i = '0;
        exp_pc     = RESET_PC;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (empty_o)
            else report_failure($sformatf("mismatch empty_o after reset: got %h, expected %h",
                                          empty_o, 1'b1));
        for (int i = 0; i < NUM_ROWS; i++) begin
            consume_entries(int'(SCENARIOS[i].consume));
            repeat (int'(SCENARIOS[i].stall)) @(posedge clk);
            if (SCENARIOS[i].redir.valid) begin
                apply_redirect(SCENARIOS[i].redir.pc);
            end
        end
        @(negedge clk);
        if (!UUT.fetch_checker_i.any_fail) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "bound assertion failed at the end of the run");
        end
    end

endmodule

//--- fetch_top.f
rtl/fetch_pkg.sv
rtl/burst_assembler.sv
rtl/line_buffer.sv
rtl/fetch_pc_gen.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fetch_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module fetch_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f fetch_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

# let bound assertion errors reach the testbench before the run stops
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0
